//--- hw/fm_types_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fm datapath types
// widths for phase, envelope and sample values of the operator engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fm_types_pkg;

    localparam int PHASE_ACC_W = 19;                   // accumulator width
    localparam int PHASE_IDX_W = 10;                   // waveform index width
    localparam int ENV_W       = 9;                    // attenuation width
    localparam int SAMPLE_W    = 13;                   // signed operator sample

    localparam int SLOT_CYCLES = 2;                    // slot_en then slot_done

    typedef logic [PHASE_ACC_W-1:0] phase_acc_t;       // top 10 bits index the table
    typedef logic [PHASE_IDX_W-1:0] phase_idx_t;
    typedef logic [ENV_W-1:0]       env_t;             // 0 full level, 511 silent
    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire

//--- hw/fm_reg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fm register fields
// per-slot register field types, waveform select and envelope states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fm_reg_pkg;

    typedef logic [9:0] fnum_t;                        // frequency number
    typedef logic [2:0] block_t;                       // octave
    typedef logic [3:0] mult_t;                        // frequency multiplier code
    typedef logic [3:0] rate_t;                        // ar, dr, sl, rr
    typedef logic [5:0] tl_t;                          // total level, 0.75 dB steps
    typedef logic [2:0] fb_t;                          // feedback depth

    typedef enum logic [1:0] {
        WAVE_SINE      = 2'd0,
        WAVE_HALF_SINE = 2'd1,                         // negative half muted
        WAVE_ABS_SINE  = 2'd2                          // rectified
    } wave_e;

    typedef enum logic [1:0] {
        ENV_ATTACK  = 2'd0,
        ENV_DECAY   = 2'd1,
        ENV_SUSTAIN = 2'd2,
        ENV_RELEASE = 2'd3
    } env_state_e;

endpackage

`default_nettype wire

//--- hw/slot_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot sequencer
// walks all operator slots once per sample strobe, two cycles per slot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module slot_sequencer #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               sample_en,           // frame strobe
    output logic [SLOT_W-1:0] slot,                // host decodes fields from this
    output logic              slot_en,             // first cycle of a slot
    output logic              slot_done,           // last cycle of a slot
    output logic              busy,
    output logic              out_valid
);
    import fm_types_pkg::*;

    localparam int POS_W = $clog2(SLOT_CYCLES);

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    seq_state_e       state;
    logic [POS_W-1:0] pos;                          // position of the coming cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            pos       <= '0;
            slot      <= '0;
            slot_en   <= 1'b0;
            slot_done <= 1'b0;
            busy      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= slot_done;                 // sample registered one cycle ago
            case (state)
                SEQ_IDLE: begin
                    slot_en   <= 1'b0;
                    slot_done <= 1'b0;
                    if (sample_en) begin            // strobe while busy never reaches here
                        state <= SEQ_RUN;
                        busy  <= 1'b1;
                        slot  <= '0;
                        pos   <= '0;
                    end
                end
                SEQ_RUN: begin
                    if (slot_done && slot == SLOT_W'(NUM_SLOTS - 1)) begin
                        state     <= SEQ_IDLE;      // busy drops with last out_valid
                        busy      <= 1'b0;
                        slot      <= '0;
                        slot_en   <= 1'b0;
                        slot_done <= 1'b0;
                    end else begin
                        if (slot_done)
                            slot <= slot + 1'b1;    // next slot starts now
                        slot_en   <= (pos == '0);
                        slot_done <= (pos == POS_W'(SLOT_CYCLES - 1));
                        pos       <= (pos == POS_W'(SLOT_CYCLES - 1)) ? '0 : pos + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/key_event_detect.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// key event detect
// per-slot key level memory giving key-on and key-off pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module key_event_detect #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [SLOT_W-1:0] slot,
    input  wire               slot_en,
    input  wire               key_on,              // current slot key level
    output logic              key_on_pulse,
    output logic              key_off_pulse
);

    logic [NUM_SLOTS-1:0] last_level;               // level seen last frame
    logic                 prev;

    always_comb begin
        prev          = last_level[slot];
        key_on_pulse  = slot_en &&  key_on && !prev; // rising level
        key_off_pulse = slot_en && !key_on &&  prev; // falling level
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last_level <= '0;                       // all keys start released
        else if (slot_en)
            last_level[slot] <= key_on;
    end

endmodule

`default_nettype wire

//--- hw/phase_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// phase unit
// per-slot phase increment, phase accumulators and phase modulation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module phase_unit #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire         [SLOT_W-1:0] slot,
    input  wire                      slot_en,
    input  wire                      key_on_pulse,
    input  wire fm_reg_pkg::fnum_t   fnum,
    input  wire fm_reg_pkg::block_t  block,
    input  wire fm_reg_pkg::mult_t   mult,
    input  wire fm_types_pkg::sample_t fb_mod,       // from feedback history
    input  wire fm_types_pkg::sample_t modulation,   // from modulator operator
    input  wire                      use_feedback,
    output fm_types_pkg::phase_idx_t phase_idx
);
    import fm_types_pkg::*;

    // OPL multiplier values, doubled so that code 0 gives one half
    localparam logic [4:0] MULT_X2 [16] = '{
        5'd1,  5'd2,  5'd4,  5'd6,  5'd8,  5'd10, 5'd12, 5'd14,
        5'd16, 5'd18, 5'd20, 5'd20, 5'd24, 5'd24, 5'd30, 5'd30
    };

    phase_acc_t  acc [NUM_SLOTS];                   // one accumulator per slot
    phase_acc_t  acc_cur;
    phase_acc_t  phase_inc;
    logic [22:0] inc_full;                          // block shift times mult x2
    sample_t     mod_sel;

    always_comb begin
        inc_full  = (23'(fnum) << block) * MULT_X2[mult];
        phase_inc = phase_acc_t'(inc_full >> 2);    // halve, undo the x2
    end

    always_comb begin
        acc_cur   = acc[slot];
        mod_sel   = use_feedback ? fb_mod : modulation;
        phase_idx = acc_cur[PHASE_ACC_W-1 -: PHASE_IDX_W] + phase_idx_t'(mod_sel); // wraps
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++)
                acc[i] <= '0;
        end else if (slot_en) begin
            if (key_on_pulse)
                acc[slot] <= '0;                    // restart phase on key-on
            else
                acc[slot] <= acc_cur + phase_inc;
        end
    end

endmodule

`default_nettype wire

//--- hw/envelope_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// envelope unit
// simplified per-slot adsr attenuation counter plus total level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module envelope_unit #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire        [SLOT_W-1:0] slot,
    input  wire                     slot_en,
    input  wire                     key_on_pulse,
    input  wire                     key_off_pulse,
    input  wire fm_reg_pkg::rate_t  ar,
    input  wire fm_reg_pkg::rate_t  dr,
    input  wire fm_reg_pkg::rate_t  sl,            // sustain level, 32 per step
    input  wire fm_reg_pkg::rate_t  rr,
    input  wire fm_reg_pkg::tl_t    tl,
    output fm_types_pkg::env_t      env
);
    import fm_types_pkg::*;
    import fm_reg_pkg::*;

    env_state_e state [NUM_SLOTS];
    env_t       att   [NUM_SLOTS];                  // 0 loud, 511 silent
    env_state_e st_cur;
    env_state_e st_nxt;
    env_t       att_cur;
    env_t       att_nxt;
    env_t       sus_lvl;
    logic [9:0] rise_dec;                           // one spare bit for overflow
    logic [9:0] rise_rel;
    logic [9:0] lvl;

    always_comb begin
        st_cur   = state[slot];
        att_cur  = att[slot];
        sus_lvl  = {sl, 5'b0};
        rise_dec = {1'b0, att_cur} + 10'(dr);
        rise_rel = {1'b0, att_cur} + 10'(rr);
        st_nxt   = st_cur;
        att_nxt  = att_cur;
        if (key_on_pulse) begin
            st_nxt = ENV_ATTACK;                    // level kept, climbs from here
        end else if (key_off_pulse) begin
            st_nxt = ENV_RELEASE;
        end else begin
            case (st_cur)
                ENV_ATTACK: begin
                    if (ar == 4'hf || att_cur <= env_t'(ar)) begin
                        att_nxt = '0;               // instant or final step
                        st_nxt  = ENV_DECAY;
                    end else begin
                        att_nxt = att_cur - env_t'(ar);
                    end
                end
                ENV_DECAY: begin
                    if (rise_dec >= {1'b0, sus_lvl}) begin
                        att_nxt = sus_lvl;
                        st_nxt  = ENV_SUSTAIN;
                    end else begin
                        att_nxt = rise_dec[8:0];
                    end
                end
                ENV_SUSTAIN: att_nxt = att_cur;     // hold until key-off
                default: att_nxt = rise_rel[9] ? 9'd511 : rise_rel[8:0]; // release
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                state[i] <= ENV_RELEASE;            // every slot starts silent
                att[i]   <= 9'd511;
            end
        end else if (slot_en) begin
            state[slot] <= st_nxt;
            att[slot]   <= att_nxt;
        end
    end

    always_comb begin
        lvl = {1'b0, att_cur} + {2'b0, tl, 2'b00}; // tl times 4
        env = lvl[9] ? 9'd511 : lvl[8:0];           // saturate
    end

endmodule

`default_nettype wire

//--- hw/wave_output.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wave output
// quarter-sine lookup, waveform shaping and envelope scaling to a sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module wave_output (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         slot_done,   // register the sample here
    input  wire fm_types_pkg::phase_idx_t phase_idx,
    input  wire fm_types_pkg::env_t     env,
    input  wire fm_reg_pkg::wave_e      wave,
    output fm_types_pkg::sample_t       out
);
    import fm_types_pkg::*;
    import fm_reg_pkg::*;

    typedef logic [11:0] quarter_tab_t [256];

    function automatic quarter_tab_t build_quarter_sine();
        quarter_tab_t tab;
        real          ang;
        for (int i = 0; i < 256; i++) begin
            ang    = (real'(i) + 0.5) * 3.14159265358979 / 512.0; // mid-step angle
            tab[i] = 12'($rtoi(4095.0 * $sin(ang) + 0.5));
        end
        return tab;
    endfunction

    localparam quarter_tab_t SINE_TAB = build_quarter_sine();

    logic [7:0]  tab_pos;
    logic [11:0] mag;
    logic        neg;
    env_t        gain;
    logic [20:0] prod;
    logic [11:0] scaled;

    always_comb begin
        tab_pos = phase_idx[8] ? ~phase_idx[7:0] : phase_idx[7:0]; // mirror 2nd quarter
        mag     = SINE_TAB[tab_pos];
        neg     = phase_idx[9];                     // second half of the cycle
        case (wave)
            WAVE_HALF_SINE: begin
                if (phase_idx[9])
                    mag = '0;
                neg = 1'b0;
            end
            WAVE_ABS_SINE: neg = 1'b0;
            default: ;                              // plain sine
        endcase
        gain   = ~env;                              // 511 - env
        prod   = mag * gain;
        scaled = prod[20:9];                        // divide by 512
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out <= '0;
        else if (slot_done)
            out <= neg ? -sample_t'({1'b0, scaled}) : sample_t'({1'b0, scaled});
    end

endmodule

`default_nettype wire

//--- hw/feedback_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// feedback store
// two-sample output history per slot and the scaled feedback term
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module feedback_store #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire           [SLOT_W-1:0] slot,
    input  wire                        slot_done,
    input  wire fm_types_pkg::sample_t out,         // freshly registered sample
    input  wire fm_reg_pkg::fb_t       fb,
    output fm_types_pkg::sample_t      fb_mod
);
    import fm_types_pkg::*;

    sample_t            hist0 [NUM_SLOTS];          // newest sample
    sample_t            hist1 [NUM_SLOTS];          // the one before
    logic [SLOT_W-1:0]  prev_slot;                  // slot whose sample is in out
    logic               latch;                      // out_valid cycle
    logic signed [13:0] fb_sum;
    logic signed [20:0] fb_wide;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_slot <= '0;
            latch     <= 1'b0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                hist0[i] <= '0;
                hist1[i] <= '0;
            end
        end else begin
            latch <= slot_done;
            if (slot_done)
                prev_slot <= slot;                  // slot moves on next edge
            if (latch) begin
                hist0[prev_slot] <= out;
                hist1[prev_slot] <= hist0[prev_slot];
            end
        end
    end

    always_comb begin
        fb_sum  = hist0[slot] + hist1[slot];
        fb_wide = fb_sum <<< fb;
        fb_mod  = (fb == '0) ? '0 : sample_t'(fb_wide >>> 9);
    end

endmodule

`default_nettype wire

//--- hw/fm_operator_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fm operator engine top
// one shared operator datapath serving all slots under the sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fm_operator_top #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        sample_en,
    input  wire                        key_on,
    input  wire fm_reg_pkg::fnum_t     fnum,
    input  wire fm_reg_pkg::block_t    block,
    input  wire fm_reg_pkg::mult_t     mult,
    input  wire fm_reg_pkg::wave_e     wave,
    input  wire fm_reg_pkg::rate_t     ar,
    input  wire fm_reg_pkg::rate_t     dr,
    input  wire fm_reg_pkg::rate_t     sl,
    input  wire fm_reg_pkg::rate_t     rr,
    input  wire fm_reg_pkg::tl_t       tl,
    input  wire fm_reg_pkg::fb_t       fb,
    input  wire                        use_feedback,
    input  wire fm_types_pkg::sample_t modulation,
    output logic          [SLOT_W-1:0] slot,
    output logic                       busy,
    output fm_types_pkg::sample_t      out,
    output logic                       out_valid
);
    import fm_types_pkg::*;

    logic       slot_en;
    logic       slot_done;
    logic       key_on_pulse;
    logic       key_off_pulse;
    sample_t    fb_mod;
    phase_idx_t phase_idx;
    env_t       env;

    slot_sequencer #(.NUM_SLOTS(NUM_SLOTS)) u_seq (
        .clk(clk), .rst_n(rst_n), .sample_en(sample_en), .slot(slot),
        .slot_en(slot_en), .slot_done(slot_done), .busy(busy), .out_valid(out_valid)
    );

    key_event_detect #(.NUM_SLOTS(NUM_SLOTS)) u_key (
        .clk(clk), .rst_n(rst_n), .slot(slot), .slot_en(slot_en), .key_on(key_on),
        .key_on_pulse(key_on_pulse), .key_off_pulse(key_off_pulse)
    );

    phase_unit #(.NUM_SLOTS(NUM_SLOTS)) u_phase (
        .clk(clk), .rst_n(rst_n), .slot(slot), .slot_en(slot_en),
        .key_on_pulse(key_on_pulse), .fnum(fnum), .block(block), .mult(mult),
        .fb_mod(fb_mod), .modulation(modulation), .use_feedback(use_feedback),
        .phase_idx(phase_idx)
    );

    envelope_unit #(.NUM_SLOTS(NUM_SLOTS)) u_env (
        .clk(clk), .rst_n(rst_n), .slot(slot), .slot_en(slot_en),
        .key_on_pulse(key_on_pulse), .key_off_pulse(key_off_pulse),
        .ar(ar), .dr(dr), .sl(sl), .rr(rr), .tl(tl), .env(env)
    );

    wave_output u_wave (
        .clk(clk), .rst_n(rst_n), .slot_done(slot_done), .phase_idx(phase_idx),
        .env(env), .wave(wave), .out(out)
    );

    feedback_store #(.NUM_SLOTS(NUM_SLOTS)) u_fb (
        .clk(clk), .rst_n(rst_n), .slot(slot), .slot_done(slot_done), .out(out),
        .fb(fb), .fb_mod(fb_mod)
    );

endmodule

`default_nettype wire

//--- dv/fm_operator_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fm operator engine testbench
// host register model plus directed tests of framing, envelope and waves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fm_operator_tb;
    import fm_types_pkg::*;
    import fm_reg_pkg::*;

    localparam int NUM_SLOTS   = 4;
    localparam int SLOT_W      = $clog2(NUM_SLOTS);
    localparam int FRAME_LIMIT = 4 * SLOT_CYCLES * NUM_SLOTS + 8; // cycles per wait

    logic              clk;
    logic              rst_n;
    logic              sample_en;
    logic              key_on;
    fnum_t             fnum;
    block_t            block;
    mult_t             mult;
    wave_e             wave;
    rate_t             ar;
    rate_t             dr;
    rate_t             sl;
    rate_t             rr;
    tl_t               tl;
    fb_t               fb;
    logic              use_feedback;
    sample_t           modulation;
    logic [SLOT_W-1:0] slot;
    logic              busy;
    sample_t           out;
    logic              out_valid;

    // host register file with one entry per slot
    logic   key_arr  [NUM_SLOTS];
    fnum_t  fnum_arr [NUM_SLOTS];
    block_t blk_arr  [NUM_SLOTS];
    mult_t  mult_arr [NUM_SLOTS];
    wave_e  wave_arr [NUM_SLOTS];
    rate_t  ar_arr   [NUM_SLOTS];
    rate_t  dr_arr   [NUM_SLOTS];
    rate_t  sl_arr   [NUM_SLOTS];
    rate_t  rr_arr   [NUM_SLOTS];
    tl_t    tl_arr   [NUM_SLOTS];
    fb_t    fb_arr   [NUM_SLOTS];
    logic   usefb_arr[NUM_SLOTS];

    int    frame_out [NUM_SLOTS];                   // samples of the last frame by slot
    int    errors;
    int    checks;
    int    tests_run;
    int    test_err0;
    int    test_chk0;
    string test_name;

    fm_operator_top #(.NUM_SLOTS(NUM_SLOTS)) UUT (
        .clk(clk), .rst_n(rst_n), .sample_en(sample_en), .key_on(key_on),
        .fnum(fnum), .block(block), .mult(mult), .wave(wave), .ar(ar), .dr(dr),
        .sl(sl), .rr(rr), .tl(tl), .fb(fb), .use_feedback(use_feedback),
        .modulation(modulation), .slot(slot), .busy(busy), .out(out),
        .out_valid(out_valid)
    );

    always #20 clk = ~clk;                          // 40 ns period

    // host presents the fields of whatever slot is current
    always @(negedge clk) begin
        key_on       = key_arr[slot];
        fnum         = fnum_arr[slot];
        block        = blk_arr[slot];
        mult         = mult_arr[slot];
        wave         = wave_arr[slot];
        ar           = ar_arr[slot];
        dr           = dr_arr[slot];
        sl           = sl_arr[slot];
        rr           = rr_arr[slot];
        tl           = tl_arr[slot];
        fb           = fb_arr[slot];
        use_feedback = usefb_arr[slot];
        modulation   = '0;                          // no external modulator
    end

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, name,
                     expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
        test_chk0 = checks;
    endtask

    task automatic end_test();
        tests_run++;
        $display("%s: done, %0d checks, %0d errors", test_name,
                 checks - test_chk0, errors - test_err0);
    endtask

    // OPL multiplier codes doubled so that code 0 is one half
    function automatic int mult_x2(input mult_t m);
        if (m == 0)
            return 1;
        else if (m <= 10)
            return 2 * m;
        else if (m == 11)
            return 20;
        else if (m <= 13)
            return 24;
        return 30;
    endfunction

    // accumulator step per frame as fnum << block times multiplier over two
    function automatic logic [18:0] phase_step(input fnum_t f, input block_t b, input mult_t m);
        logic [31:0] wide;
        wide = (32'(f) << b) * mult_x2(m);
        return 19'(wide >> 2);
    endfunction

    // frames from key-off until env saturates including the key-off frame
    function automatic int release_frames(input int att0, input int tl_v, input int rr_v);
        int span;
        span = 511 - 4 * tl_v - att0;
        if (span <= 0)
            return 1;
        return 1 + (span + rr_v - 1) / rr_v;
    endfunction

    task automatic clear_fields();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            key_arr[s]   = 1'b0;
            fnum_arr[s]  = '0;
            blk_arr[s]   = '0;
            mult_arr[s]  = 4'd1;
            wave_arr[s]  = WAVE_SINE;
            ar_arr[s]    = 4'd15;
            dr_arr[s]    = '0;
            sl_arr[s]    = '0;                      // sustain at full level
            rr_arr[s]    = 4'd15;
            tl_arr[s]    = '0;
            fb_arr[s]    = '0;
            usefb_arr[s] = 1'b0;
        end
    endtask

    // one sample strobe collecting one sample per slot
    task automatic run_frame();
        int k;
        int waited;
        k = 0;
        waited = 0;
        @(negedge clk);
        sample_en = 1'b1;
        while (k < NUM_SLOTS && waited < FRAME_LIMIT) begin
            @(negedge clk);
            sample_en = 1'b0;
            waited++;
            if (out_valid) begin
                frame_out[k] = out;
                k++;
            end
        end
        if (k < NUM_SLOTS) begin
            errors++;
            $display("timeout: only %0d of %0d samples arrived in a frame", k, NUM_SLOTS);
        end
        waited = 0;
        while (busy && waited < FRAME_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            errors++;
            $display("timeout: busy stayed high after the frame ended");
        end
    endtask

    // key everything off and wait out the slowest release
    task automatic release_all();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            key_arr[s] = 1'b0;
            rr_arr[s]  = 4'd15;
            tl_arr[s]  = '0;
        end
        repeat (release_frames(0, 0, 15)) run_frame();
    endtask

    task automatic reset_idle_test();
        begin_test("reset state");
        repeat (12) begin
            @(negedge clk);
            check_value("reset busy", 0, busy);
            check_value("reset out_valid", 0, out_valid);
            check_value("reset out", 0, out);
            check_value("reset slot", 0, slot);
        end
        end_test();
    endtask

    task automatic frame_walk_test();
        int cyc;
        int fall_cyc;
        int pulses [$];
        begin_test("frame walk");
        fall_cyc = -1;
        cyc = -1;
        @(negedge clk);
        sample_en = 1'b1;
        while (fall_cyc < 0 && cyc < FRAME_LIMIT) begin
            @(negedge clk);
            cyc++;                                  // cycles since the strobe edge
            sample_en = (cyc == 2);                 // second strobe lands while busy
            if (out_valid) begin
                pulses.push_back(cyc);
                check_value("frame walk next slot", pulses.size() % NUM_SLOTS, slot);
            end
            if (!busy)
                fall_cyc = cyc;
        end
        sample_en = 1'b0;
        if (fall_cyc < 0) begin
            errors++;
            $display("timeout: busy never fell during the frame walk");
        end
        repeat (2 * SLOT_CYCLES * NUM_SLOTS) begin  // idle tail where no pulse may follow
            @(negedge clk);
            if (out_valid)
                pulses.push_back(-1);
            check_value("frame walk busy after frame", 0, busy);
        end
        check_value("frame walk pulse count", NUM_SLOTS, pulses.size());
        for (int k = 0; k < NUM_SLOTS && k < pulses.size(); k++)
            check_value("frame walk pulse offset", 1 + SLOT_CYCLES * k + SLOT_CYCLES,
                        pulses[k]);
        check_value("frame walk busy fall", 1 + SLOT_CYCLES * NUM_SLOTS, fall_cyc);
        end_test();
    endtask

    task automatic silence_test();
        begin_test("silence");
        key_arr[1]  = 1'b1;
        fnum_arr[1] = 10'd700;
        blk_arr[1]  = 3'd4;
        repeat (4) begin
            run_frame();
            check_value("silence never keyed", 0, frame_out[0]);
        end
        tl_arr[1]  = 6'd63;
        rr_arr[1]  = 4'd15;
        key_arr[1] = 1'b0;
        repeat (release_frames(0, 63, 15)) begin
            run_frame();
            check_value("silence never keyed", 0, frame_out[0]);
        end
        repeat (8) begin
            run_frame();
            check_value("silence never keyed", 0, frame_out[0]);
            check_value("silence released", 0, frame_out[1]);
        end
        end_test();
    endtask

    task automatic waveform_test();
        int          pos_cnt [3];
        int          neg_cnt [3];
        logic [18:0] step;
        begin_test("waveforms");
        release_all();
        for (int s = 0; s < 3; s++) begin
            pos_cnt[s] = 0;
            neg_cnt[s] = 0;
            do begin                                // keep away from a near-zero step
                fnum_arr[s] = fnum_t'($urandom_range(1023, 1));
                blk_arr[s]  = block_t'($urandom_range(7, 0));
                mult_arr[s] = mult_t'($urandom_range(15, 0));
                step        = phase_step(fnum_arr[s], blk_arr[s], mult_arr[s]);
            end while (step < 19'h02000 || step > 19'h7e000);
            key_arr[s] = 1'b1;
        end
        wave_arr[0] = WAVE_SINE;
        wave_arr[1] = WAVE_HALF_SINE;
        wave_arr[2] = WAVE_ABS_SINE;
        repeat (64) begin
            run_frame();
            for (int s = 0; s < 3; s++) begin
                if (frame_out[s] > 0)
                    pos_cnt[s]++;
                if (frame_out[s] < 0)
                    neg_cnt[s]++;
            end
        end
        check_value("sine shows positive", 1, pos_cnt[0] > 0);
        check_value("sine shows negative", 1, neg_cnt[0] > 0);
        check_value("half sine negatives", 0, neg_cnt[1]);
        check_value("half sine sounds", 1, pos_cnt[1] > 0);
        check_value("abs sine negatives", 0, neg_cnt[2]);
        check_value("abs sine sounds", 1, pos_cnt[2] > 0);
        wave_arr[1] = WAVE_SINE;
        wave_arr[2] = WAVE_SINE;
        end_test();
    endtask

    task automatic envelope_test();
        int peak;
        int prev_peak;
        int first_peak;
        int limit;
        begin_test("envelope");
        release_all();
        fnum_arr[0] = 10'd512;                      // step of 1/8 cycle per frame
        blk_arr[0]  = 3'd7;
        mult_arr[0] = 4'd2;
        ar_arr[0]   = 4'd4;                         // slow attack over 128 frames
        key_arr[0]  = 1'b1;
        run_frame();                                // key-on frame
        prev_peak  = 0;
        first_peak = -1;
        for (int p = 0; p < 17; p++) begin
            peak = 0;
            repeat (8) begin
                run_frame();
                if (frame_out[0] > peak)
                    peak = frame_out[0];
                if (-frame_out[0] > peak)
                    peak = -frame_out[0];
            end
            if (first_peak < 0)
                first_peak = peak;
            check_value("attack peak not falling", 1, peak >= prev_peak);
            prev_peak = peak;
        end
        check_value("attack peak rises", 1, prev_peak > first_peak);
        key_arr[0] = 1'b0;
        rr_arr[0]  = 4'd15;
        limit = release_frames(0, 0, 15);
        repeat (limit) run_frame();
        check_value("release reaches zero", 0, frame_out[0]);
        repeat (3) begin
            run_frame();
            check_value("release stays zero", 0, frame_out[0]);
        end
        clear_fields();
        end_test();
    endtask

    task automatic feedback_test();
        int diff_frames;
        begin_test("feedback");
        release_all();
        for (int s = 0; s < 3; s++) begin
            fnum_arr[s]  = 10'd400;
            blk_arr[s]   = 3'd5;
            mult_arr[s]  = 4'd1;
            fb_arr[s]    = 3'd0;
            usefb_arr[s] = (s < 2);                 // slot 2 is the plain reference
            key_arr[s]   = 1'b1;
        end
        repeat (20) begin
            run_frame();
            check_value("fb 0 slot 0 vs plain", frame_out[2], frame_out[0]);
            check_value("fb 0 slot 1 vs plain", frame_out[2], frame_out[1]);
        end
        release_all();
        for (int s = 0; s < 3; s++) begin
            fb_arr[s]  = 3'd7;
            key_arr[s] = 1'b1;
        end
        diff_frames = 0;
        repeat (20) begin
            run_frame();
            check_value("fb 7 twin slots", frame_out[0], frame_out[1]);
            if (frame_out[0] != frame_out[2])
                diff_frames++;
        end
        check_value("fb 7 changes output", 1, diff_frames > 0);
        end_test();
    endtask

    initial begin
        void'($urandom(31300));
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        sample_en    = 1'b0;
        key_on       = 1'b0;
        fnum         = '0;
        block        = '0;
        mult         = '0;
        wave         = WAVE_SINE;
        ar           = '0;
        dr           = '0;
        sl           = '0;
        rr           = '0;
        tl           = '0;
        fb           = '0;
        use_feedback = 1'b0;
        modulation   = '0;
        clear_fields();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        reset_idle_test();
        frame_walk_test();
        silence_test();
        waveform_test();
        envelope_test();
        feedback_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hw/fm_types_pkg.sv
hw/fm_reg_pkg.sv
hw/slot_sequencer.sv
hw/key_event_detect.sv
hw/phase_unit.sv
hw/envelope_unit.sv
hw/wave_output.sv
hw/feedback_store.sv
hw/fm_operator_top.sv
dv/fm_operator_tb.sv
